/* hw/audio_pkg.sv */
package audio_pkg;

    //--------------------------------------------------------------------
    // Sample widths
    //--------------------------------------------------------------------

    localparam int w_mic    = 24;  // Microphone word
    localparam int w_sample = 16;  // DAC word

    //--------------------------------------------------------------------
    // I2S timing, counted in clk cycles and bclk periods
    //--------------------------------------------------------------------

    localparam int mclk_div   = 4;   // clk cycles per mclk
    localparam int bclk_div   = 16;  // clk cycles per bclk
    localparam int slot_bits  = 32;  // bclk periods per channel
    localparam int frame_bits = 64;  // Left plus right slot

    typedef logic signed [w_mic    - 1:0] mic_sample_t;  // Two's complement
    typedef logic signed [w_sample - 1:0] audio_sample_t;

    typedef logic [$clog2 (bclk_div)   - 1:0] div_cnt_t;  // Position inside a bclk
    typedef logic [$clog2 (frame_bits) - 1:0] bit_cnt_t;  // Bit index in a frame

endpackage

/* hw/board_pkg.sv */
package board_pkg;

    //--------------------------------------------------------------------
    // Board-facing widths
    //--------------------------------------------------------------------

    localparam int w_key = 4;  // Push buttons
    localparam int w_sw  = 3;  // Slide switches
    localparam int w_led = 8;  // Level meter LEDs

    //--------------------------------------------------------------------
    // Vector types
    //--------------------------------------------------------------------

    // Pressed keys, active high once past the pins
    typedef logic [w_key - 1:0] key_t;

    typedef logic [w_sw  - 1:0] sw_t;   // Attenuation shift amount
    typedef logic [w_led - 1:0] led_t;  // One bit per meter LED

endpackage

/* hw/board_top.sv */
`timescale 1ns/1ns

module board_top
(
    input                     clk,
    input                     rst,

    input  board_pkg::key_t   key_n,      // Active low at the pin
    input  board_pkg::sw_t    sw,
    input                     mic_sd,

    output                    mic_sck,
    output                    mic_ws,
    output                    dac_mclk,
    output                    dac_bclk,
    output                    dac_lrclk,
    output                    dac_sdata,
    output board_pkg::led_t   led
);

    import board_pkg::*;
    import audio_pkg::*;

    key_t          key;          // Pressed keys, active high
    logic          sd_meta;      // First synchronizer stage
    logic          sd_sync;      // Mic data in the clk domain

    logic          mclk;
    logic          bclk;
    logic          lrclk;
    logic          bit_rise;
    logic          bit_fall;
    logic          frame_start;
    bit_cnt_t      bit_cnt;

    mic_sample_t   mic_sample;
    logic          mic_valid;
    audio_sample_t sample;       // Lab core result toward the DAC
    logic          sdata;

    logic          mclk_q;       // Pin registers
    logic          bclk_q;
    logic          lrclk_q;
    logic          sdata_q;

    assign key = ~ key_n;

    //--------------------------------------------------------------------
    // Microphone data synchronizer
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sd_meta <= 1'b0;
            sd_sync <= 1'b0;
        end
        else
        begin
            sd_meta <= mic_sd;
            sd_sync <= sd_meta;
        end
    end

    //--------------------------------------------------------------------
    // Audio path
    //--------------------------------------------------------------------

    i2s_clock_gen i_clock_gen
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .mclk        ( mclk        ),
        .bclk        ( bclk        ),
        .lrclk       ( lrclk       ),
        .bit_rise    ( bit_rise    ),
        .bit_fall    ( bit_fall    ),
        .frame_start ( frame_start ),
        .bit_cnt     ( bit_cnt     )
    );

    i2s_mic_receiver i_microphone
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sd         ( sd_sync    ),
        .bit_rise   ( bit_rise   ),
        .bit_cnt    ( bit_cnt    ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  )
    );

    lab_top i_lab
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .key        ( key        ),
        .sw         ( sw         ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  ),
        .sample     ( sample     ),
        .led        ( led        )
    );

    i2s_audio_out o_audio
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .sample      ( sample      ),
        .bit_fall    ( bit_fall    ),
        .frame_start ( frame_start ),
        .bit_cnt     ( bit_cnt     ),
        .sdata       ( sdata       )
    );

    // Output stage against glitches on the I2S pins
    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk_q  <= 1'b0;
            bclk_q  <= 1'b0;
            lrclk_q <= 1'b0;
            sdata_q <= 1'b0;
        end
        else
        begin
            mclk_q  <= mclk;
            bclk_q  <= bclk;
            lrclk_q <= lrclk;
            sdata_q <= sdata;
        end
    end

    assign mic_sck   = bclk_q;   // Mic and DAC share one bit clock
    assign dac_bclk  = bclk_q;
    assign mic_ws    = lrclk_q;  // Low selects the left slot
    assign dac_lrclk = lrclk_q;
    assign dac_mclk  = mclk_q;
    assign dac_sdata = sdata_q;

endmodule

/* hw/i2s_audio_out.sv */
`timescale 1ns/1ns

module i2s_audio_out
(
    input                             clk,
    input                             rst,
    input  audio_pkg::audio_sample_t  sample,
    input                             bit_fall,
    input                             frame_start,
    input  audio_pkg::bit_cnt_t       bit_cnt,
    output logic                      sdata
);

    import audio_pkg::*;

    audio_sample_t shift_reg;  // Word for the current left slot
    logic          in_window;  // Next bit is one of 1 to 16

    // bit_cnt still holds the bit that is ending
    assign in_window = bit_cnt < bit_cnt_t' (w_sample);

    //--------------------------------------------------------------------
    // Shift register
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            shift_reg <= '0;
        else if (frame_start)
            shift_reg <= sample;  // Latest lab core result
        else if (bit_fall && in_window)
            shift_reg <= shift_reg << 1;
    end

    //--------------------------------------------------------------------
    // Serial data
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            sdata <= 1'b0;
        else if (bit_fall)
            sdata <= in_window & shift_reg [w_sample - 1];  // Zero outside bits 1 to 16
    end

    // Data moves together with the falling bclk
    assert property (@ (posedge clk) disable iff (rst)
        $changed (sdata) |-> $past (bit_fall));

endmodule

/* hw/i2s_clock_gen.sv */
`timescale 1ns/1ns

module i2s_clock_gen
(
    input                         clk,
    input                         rst,
    output                        mclk,
    output                        bclk,
    output                        lrclk,
    output                        bit_rise,     // bclk rises next cycle
    output                        bit_fall,     // bclk falls next cycle
    output                        frame_start,  // Bit 0 starts next cycle
    output audio_pkg::bit_cnt_t   bit_cnt
);

    import audio_pkg::*;

    div_cnt_t div_cnt;  // Position inside one bclk period

    //--------------------------------------------------------------------
    // Bit clock divider
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;  // Wraps every bclk_div cycles
    end

    assign mclk     = div_cnt [$clog2 (mclk_div) - 1];  // Divide by 4
    assign bclk     = div_cnt [$clog2 (bclk_div) - 1];  // Low half, then high half
    assign bit_rise = div_cnt == div_cnt_t' (bclk_div / 2 - 1);
    assign bit_fall = div_cnt == div_cnt_t' (bclk_div - 1);

    //--------------------------------------------------------------------
    // Frame bit counter
    //--------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (bit_fall)
            bit_cnt <= bit_cnt + 1'b1;  // Steps together with bclk falling
    end

    assign lrclk       = bit_cnt >= bit_cnt_t' (slot_bits);  // High in right slot
    assign frame_start = bit_fall & (bit_cnt == bit_cnt_t' (frame_bits - 1));

    // Rise and fall strobes never share a cycle
    assert property (@ (posedge clk) disable iff (rst) !(bit_rise && bit_fall));

    // Word select moves only with a falling bclk
    assert property (@ (posedge clk) disable iff (rst)
        $changed (lrclk) |-> $past (bit_fall));

endmodule

/* hw/i2s_mic_receiver.sv */
`timescale 1ns/1ns

module i2s_mic_receiver
(
    input                           clk,
    input                           rst,
    input                           sd,          // Already synchronized
    input                           bit_rise,
    input  audio_pkg::bit_cnt_t     bit_cnt,
    output audio_pkg::mic_sample_t  mic_sample,
    output logic                    mic_valid    // One cycle per frame
);

    import audio_pkg::*;

    mic_sample_t shift_reg;   // Word being assembled
    mic_sample_t shift_next;
    logic        in_window;   // Left slot bits 1 to 24
    logic        last_bit;

    //--------------------------------------------------------------------
    // Serial capture
    //--------------------------------------------------------------------

    assign in_window  = (bit_cnt >= bit_cnt_t' (1)) && (bit_cnt <= bit_cnt_t' (w_mic));
    assign last_bit   = bit_rise && (bit_cnt == bit_cnt_t' (w_mic));
    assign shift_next = {shift_reg [w_mic - 2:0], sd};  // MSB arrives first

    always_ff @ (posedge clk)
    begin
        if (bit_rise && in_window)
            shift_reg <= shift_next;
    end

    //--------------------------------------------------------------------
    // Word output
    //--------------------------------------------------------------------

    always_ff @ (posedge clk)
    begin
        if (last_bit)
            mic_sample <= shift_next;  // Includes the bit taken this cycle
    end

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            mic_valid <= 1'b0;
        else
            mic_valid <= last_bit;
    end

    // One word per frame, strobe never stretches
    assert property (@ (posedge clk) disable iff (rst) mic_valid |=> !mic_valid);

endmodule

/* hw/lab_top.sv */
`timescale 1ns/1ns

module lab_top
(
    input                             clk,
    input                             rst,
    input  board_pkg::key_t           key,
    input  board_pkg::sw_t            sw,
    input  audio_pkg::mic_sample_t    mic_sample,
    input                             mic_valid,
    output audio_pkg::audio_sample_t  sample,
    output board_pkg::led_t           led
);

    import board_pkg::*;
    import audio_pkg::*;

    audio_sample_t                  top_bits;     // Upper part of the mic word
    audio_sample_t                  attenuated;
    audio_sample_t                  magnitude;    // Clipped absolute value
    audio_sample_t                  sample_next;
    logic [$clog2 (w_sample) - 1:0] bit_len;      // 0 to 15
    led_t                           led_next;

    // Position of the highest set bit plus one
    function automatic logic [$clog2 (w_sample) - 1:0] bit_length (audio_sample_t v);
        logic [$clog2 (w_sample) - 1:0] len;
        len = '0;
        for (int i = 0; i < w_sample - 1; i ++)
            if (v [i])
                len = ($clog2 (w_sample))' (i + 1);
        return len;
    endfunction

    //--------------------------------------------------------------------
    // Sample and meter calculation
    //--------------------------------------------------------------------

    always_comb
    begin
        top_bits   = mic_sample [w_mic - 1 -: w_sample];
        attenuated = top_bits >>> sw;  // Sign bit fills from the left

        if (!top_bits [w_sample - 1])
            magnitude = top_bits;
        else if (top_bits == {1'b1, {(w_sample - 1) {1'b0}}})
            magnitude = {1'b0, {(w_sample - 1) {1'b1}}};  // Most negative clips
        else
            magnitude = - top_bits;

        bit_len = bit_length (magnitude);

        for (int i = 0; i < w_led; i ++)
            led_next [i] = i < bit_len / 2;  // Bar graph from LED 0 up

        if (|key)
            sample_next = '0;  // Any held key mutes
        else
            sample_next = attenuated;
    end

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample <= '0;
            led    <= '0;
        end
        else if (mic_valid)
        begin
            sample <= sample_next;
            led    <= led_next;
        end
    end

endmodule

/* i2s_board.f */
hw/board_pkg.sv
hw/audio_pkg.sv
hw/i2s_clock_gen.sv
hw/i2s_mic_receiver.sv
hw/lab_top.sv
hw/i2s_audio_out.sv
hw/board_top.sv
verification/tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the board-level testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f i2s_board.f -o tb_board_top

./obj_dir/tb_board_top > sim.log
cat sim.log

if grep -q "Verification failed" sim.log
then
    exit 1
fi

/* verification/tb_board_top.sv */
`timescale 1ns/1ns

module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int clk_period    = 10;
    localparam int frame_cycles  = frame_bits * bclk_div;  // 1024 clk per frame
    localparam int frame_timeout = 4 * frame_cycles;

    logic          clk;
    logic          rst;
    key_t          key_n;
    sw_t           sw;
    logic          mic_sd;
    logic          mic_sck;
    logic          mic_ws;
    logic          dac_mclk;
    logic          dac_bclk;
    logic          dac_lrclk;
    logic          dac_sdata;
    led_t          led;

    mic_sample_t   cur_word;         // Word sent in the running frame
    mic_sample_t   forced_words [$]; // Sent before any random word
    int            amp_shift;        // Scales random words down
    audio_sample_t exp_word;         // Expected DAC word this frame
    led_t          exp_led;
    logic          exp_sdata;
    int            bit_idx;          // Bit in frame as seen at the pins
    int            frame_count;
    logic          ws_prev;
    sw_t           next_sw;          // Applied at the next frame start
    key_t          next_key_n;
    int            error_count;
    int            tests_run;
    int            tests_failed;
    logic          timed_out;

    logic [2:0]    pins;             // lrclk, bclk, mclk
    logic [2:0]    pins_prev;
    logic [2:0]    armed;            // First edge seen
    int            since_change [3];

    board_top i_dut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key_n     ( key_n     ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .dac_mclk  ( dac_mclk  ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata ),
        .led       ( led       )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~ clk;
    end

    //----------------------------------------------------------------------
    // Reference rules for the lab core
    //----------------------------------------------------------------------

    function automatic audio_sample_t expected_sample (mic_sample_t word, sw_t shift,
                                                       key_t keys_n);
        audio_sample_t upper;
        upper = word [w_mic - 1 -: w_sample];
        if (keys_n != '1)
            return '0;                       // Any pressed key mutes
        return upper >>> shift;
    endfunction

    function automatic led_t expected_meter (mic_sample_t word);
        audio_sample_t upper;
        int            mag;
        int            len;
        led_t          bar;
        upper = word [w_mic - 1 -: w_sample];
        mag   = upper;                       // Sign extends
        if (mag < 0)
            mag = - mag;
        if (mag > 32767)
            mag = 32767;
        len = 0;
        while (mag > 0)
        begin
            len++;
            mag = mag >> 1;
        end
        bar = '0;
        for (int i = 0; i < len / 2; i++)
            bar [i] = 1'b1;
        return bar;
    endfunction

    function automatic mic_sample_t pick_word ();
        mic_sample_t raw;
        if (forced_words.size () > 0)
            return forced_words.pop_front ();
        raw = mic_sample_t' ($urandom);
        return raw >>> amp_shift;
    endfunction

    //----------------------------------------------------------------------
    // Microphone model stepping on the falling mic_sck
    //----------------------------------------------------------------------

    task automatic start_mic_frame;
        exp_word    = expected_sample (cur_word, sw, key_n);  // Previous frame decides
        exp_led     = expected_meter (cur_word);
        cur_word    = pick_word ();
        sw          = next_sw;
        key_n       = next_key_n;
        bit_idx     = 0;
        frame_count++;
    endtask

    always @ (negedge mic_sck)
    begin
        #1;
        if (ws_prev && !mic_ws)
            start_mic_frame ();              // Falling ws marks bit 0
        else
            bit_idx++;
        ws_prev = mic_ws;
        if (bit_idx >= 1 && bit_idx <= w_mic)
            mic_sd = cur_word [w_mic - bit_idx];  // MSB in bit 1
        else
            mic_sd = 1'b0;
    end

    assign exp_sdata = (bit_idx >= 1 && bit_idx <= w_sample) ?
                       exp_word [w_sample - bit_idx] : 1'b0;

    //----------------------------------------------------------------------
    // Clock pin spacing
    //----------------------------------------------------------------------

    assign pins = {dac_lrclk, dac_bclk, dac_mclk};

    always @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pins_prev <= '0;
            armed     <= '0;
            for (int i = 0; i < 3; i++)
                since_change [i] <= 0;
        end
        else
        begin
            pins_prev <= pins;
            for (int i = 0; i < 3; i++)
                if (pins [i] != pins_prev [i])
                begin
                    armed [i]        <= 1'b1;
                    since_change [i] <= 1;   // Cycle of the new level
                end
                else
                    since_change [i] <= since_change [i] + 1;
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------

    assert property (@ (posedge clk) (rst || $fell (rst)) |->
        (!dac_bclk && !dac_lrclk && !dac_mclk && !dac_sdata && led == '0))
    else
    begin
        error_count++;
        $display("error reset outputs: dac_bclk %h dac_lrclk %h dac_mclk %h dac_sdata %h led %h",
            dac_bclk, dac_lrclk, dac_mclk, dac_sdata, led);
    end

    assert property (@ (posedge clk) disable iff (rst)
        (armed [0] && pins [0] != pins_prev [0]) |-> since_change [0] == mclk_div / 2)
    else
    begin
        error_count++;
        $display("error dac_mclk half period: expected %h, got %h", mclk_div / 2,
            since_change [0]);
    end

    assert property (@ (posedge clk) disable iff (rst)
        (armed [1] && pins [1] != pins_prev [1]) |-> since_change [1] == bclk_div / 2)
    else
    begin
        error_count++;
        $display("error dac_bclk half period: expected %h, got %h", bclk_div / 2,
            since_change [1]);
    end

    // Each slot lasts half a frame with the left slot first
    assert property (@ (posedge clk) disable iff (rst)
        (armed [2] && pins [2] != pins_prev [2]) |-> since_change [2] == frame_cycles / 2)
    else
    begin
        error_count++;
        $display("error dac_lrclk half period: expected %h, got %h", frame_cycles / 2,
            since_change [2]);
    end

    assert property (@ (posedge clk) mic_sck == dac_bclk)
    else
    begin
        error_count++;
        $display("error mic_sck: expected %h, got %h", dac_bclk, mic_sck);
    end

    assert property (@ (posedge clk) mic_ws == dac_lrclk)
    else
    begin
        error_count++;
        $display("error mic_ws: expected %h, got %h", dac_lrclk, mic_ws);
    end

    // Every one of the 64 bits with zeros outside bits 1 to 16
    assert property (@ (posedge dac_bclk) disable iff (rst) dac_sdata == exp_sdata)
    else
    begin
        error_count++;
        $display("error dac_sdata frame %0d bit %0d: expected %h, got %h",
            frame_count, bit_idx, exp_sdata, dac_sdata);
    end

    assert property (@ (posedge dac_bclk) disable iff (rst) bit_idx == 0 |-> led == exp_led)
    else
    begin
        error_count++;
        $display("error led frame %0d: expected %h, got %h", frame_count, exp_led, led);
    end

    //----------------------------------------------------------------------
    // Sequencing
    //----------------------------------------------------------------------

    task automatic wait_frames (input int count);
        int target;
        int cycles;
        for (int n = 0; n < count && !timed_out; n++)
        begin
            target = frame_count + 1;
            cycles = 0;
            while (frame_count < target && cycles < frame_timeout)
            begin
                @ (posedge clk);
                cycles++;
            end
            if (frame_count < target)
            begin
                timed_out = 1'b1;
                error_count++;
                $display("timeout: no new frame on mic_ws within %0d clk cycles",
                    frame_timeout);
            end
        end
    endtask

    task automatic report_test (input string name, input int errors_before);
        int new_errors;
        new_errors = error_count - errors_before;
        tests_run++;
        if (new_errors == 0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, new_errors);
        end
    endtask

    initial
    begin
        int errors_before;

        void' ($urandom (32'h79f78352));
        rst          = 1'b1;
        key_n        = '1;
        sw           = '0;
        mic_sd       = 1'b0;
        next_key_n   = '1;
        next_sw      = '0;
        amp_shift    = 0;
        bit_idx      = 0;                    // Reset leaves the DUT in bit 0
        frame_count  = 0;
        ws_prev      = 1'b0;
        exp_word     = '0;
        exp_led      = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        cur_word     = pick_word ();

        errors_before = error_count;
        repeat (5) @ (posedge clk);
        #1 rst = 1'b0;
        repeat (2) @ (posedge clk);
        report_test ("reset values", errors_before);

        errors_before = error_count;
        wait_frames (3);
        report_test ("I2S clock periods", errors_before);

        errors_before = error_count;
        wait_frames (4);                     // sw at 0 and keys released
        report_test ("loopback", errors_before);

        errors_before = error_count;
        for (int s = 0; s < 8; s++)
        begin
            next_sw = sw_t' (s);
            wait_frames (2);
        end
        next_sw = '0;
        wait_frames (2);
        report_test ("attenuation", errors_before);

        errors_before = error_count;
        for (int k = 0; k < w_key; k++)
        begin
            next_key_n = ~ (key_t' (1) << k);  // One key at a time
            wait_frames (2);
        end
        next_key_n = 4'b0110;                // Two keys at once
        wait_frames (2);
        next_key_n = '1;
        wait_frames (3);                     // Output back one frame later
        report_test ("key mute", errors_before);

        errors_before = error_count;
        forced_words.push_back (24'h000000);
        forced_words.push_back (24'h000100);
        forced_words.push_back (24'hffff00);
        forced_words.push_back (24'h7fffff);
        forced_words.push_back (24'h800000); // Most negative word clips
        forced_words.push_back (24'h008000);
        wait_frames (forced_words.size () + 2);
        for (int sh = 0; sh < w_mic; sh++)
        begin
            amp_shift = sh;                  // Small words down to zero
            wait_frames (1);
        end
        amp_shift = 0;
        wait_frames (2);
        report_test ("level meter", errors_before);

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
            error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
